/* Bender.yml */
package:
  name: de_fill

sources:
  - verilog/de_pkg.sv
  - verilog/de_regs.sv
  - verilog/de_blt_fill.sv
  - verilog/de_host_window.sv
  - verilog/de_fb_arb.sv
  - verilog/de_top.sv
  - target: simulation
    files:
      - sim/tb_de_top.sv

/* sim/tb_de_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_de_top import de_pkg::*; ();

  logic              hb_clk;
  logic              rst_n;
  logic              hb_csn_de;
  logic              hb_wstrb;
  logic [REG_AW-1:0] hb_adr;
  logic [PIX_W-1:0]  hb_din;
  logic [PIX_W-1:0]  hb_dout;
  logic              hb_xyw_csn;
  logic [FB_AW-1:0]  hb_win_adr;
  logic              busy_hb;
  logic              fb_we;
  logic [FB_AW-1:0]  fb_addr;
  logic [PIX_W-1:0]  fb_data;
  logic              mc_busy;
  logic              dx_deb;
  logic              de_ddint_tog;
  logic              interrupt;

  logic [FB_AW-1:0] exp_q[$];          // Fill addresses still owed
  logic [PIX_W-1:0] exp_data;
  logic             win_pending;
  logic [FB_AW-1:0] win_exp_addr;
  logic [PIX_W-1:0] win_exp_data;
  logic             tog_exp;           // Flips once per command
  int               fill_writes;
  logic             stall_en;
  logic [15:0]      lfsr;
  int               wd_cycles;
  logic             wd_armed = 1'b0;

  de_top de_top_inst (
    .hb_clk, .rst_n, .hb_csn_de, .hb_wstrb, .hb_adr, .hb_din, .hb_dout,
    .hb_xyw_csn, .hb_win_adr, .busy_hb, .fb_we, .fb_addr, .fb_data,
    .mc_busy, .dx_deb, .de_ddint_tog, .interrupt
  );

  initial begin
    hb_clk = 1'b0;
    forever #5 hb_clk = ~hb_clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error: %s is %h, expected %h", name, got, exp));
  endtask

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Address of pixel idx in row-major order
  function automatic logic [FB_AW-1:0] ref_fill_addr(input logic [FB_AW-1:0] org,
      input int pit, input int x0, input int y0, input int w, input int idx);
    int row;
    int col;
    row = idx / w;
    col = idx % w;
    return org + FB_AW'((y0 + row) * pit) + FB_AW'(x0 + col);
  endfunction

  task automatic next_cycle();
    @(posedge hb_clk);
    #1;
  endtask

  task automatic reg_write(input logic [REG_AW-1:0] adr, input logic [PIX_W-1:0] data);
    hb_csn_de = 1'b0;
    hb_wstrb  = 1'b1;
    hb_adr    = adr;
    hb_din    = data;
    next_cycle();
    hb_csn_de = 1'b1;
    hb_wstrb  = 1'b0;
  endtask

  task automatic check_reg(input logic [REG_AW-1:0] adr, input logic [PIX_W-1:0] exp,
                           input string name);
    hb_adr = adr;
    @(posedge hb_clk);
    check_value(name, hb_dout, exp);
    #1;
  endtask

  task automatic run_fill(input logic [FB_AW-1:0] org, input logic [11:0] pit,
      input logic [11:0] x0, input logic [11:0] y0, input logic [11:0] w,
      input logic [11:0] h, input logic [31:0] color, input bit ie,
      input bit stall, input bit win);
    int   writes_before;
    logic [FB_AW-1:0] win_off;
    reg_write(REG_DORG, PIX_W'(org));
    reg_write(REG_PITCH, PIX_W'(pit));
    reg_write(REG_FORE, color);
    reg_write(REG_XY0, {4'h0, y0, 4'h0, x0});
    reg_write(REG_WH, {4'h0, h, 4'h0, w});
    for (int i = 0; i < int'(w) * int'(h); i++)
      exp_q.push_back(ref_fill_addr(org, pit, x0, y0, w, i));
    exp_data      = color;
    tog_exp       = !tog_exp;
    writes_before = fill_writes;
    stall_en      = stall;
    reg_write(REG_CMD, {30'd0, ie, 1'b1});
    @(posedge hb_clk);
    while (!dx_deb) @(posedge hb_clk);
    #1;
    if (win) begin
      repeat (2) next_cycle();
      win_off      = FB_AW'((y0 + h + 2) * pit); // Below the rectangle
      win_exp_addr = org + win_off;
      win_exp_data = ~color;
      win_pending  = 1'b1;
      hb_xyw_csn   = 1'b0;
      hb_wstrb     = 1'b1;
      hb_win_adr   = win_off;
      hb_din       = ~color;
      next_cycle();
      hb_xyw_csn   = 1'b1;
      hb_wstrb     = 1'b0;
      check_value("busy_hb", busy_hb, 1);
    end
    @(posedge hb_clk);
    while (dx_deb) @(posedge hb_clk);
    check_value("de_ddint_tog", de_ddint_tog, tog_exp);
    check_value("fill write count", fill_writes - writes_before, w * h);
    check_value("interrupt", interrupt, ie);
    check_value("win_pending", win_pending, 0);
    #1;
    stall_en = 1'b0;
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  always @(posedge hb_clk) begin
    if (rst_n && fb_we) begin
      if (mc_busy)
        fail_run("Frame buffer write issued while mc_busy was high");
      if (win_pending && fb_addr == win_exp_addr) begin
        check_value("fb_data", fb_data, win_exp_data);
        win_pending = 1'b0;                // Second copy would hit the fill queue
      end else if (exp_q.size() == 0) begin
        fail_run($sformatf("Unexpected frame buffer write to address %h", fb_addr));
      end else begin
        check_value("fb_addr", fb_addr, exp_q.pop_front());
        check_value("fb_data", fb_data, exp_data);
        fill_writes++;
      end
    end
  end

  // Memory controller stalls
  always begin : stall_gen
    logic [31:0] bit_val;
    @(posedge hb_clk);
    #1;
    if (stall_en) begin
      rand_bits(1, bit_val);
      mc_busy = bit_val[0];
    end else begin
      mc_busy = 1'b0;
    end
  end

  initial begin
    wait (wd_armed);
    repeat (wd_cycles) @(posedge hb_clk);
    fail_run("Run timed out before all tests finished");
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [11:0] rw, rh, rx, ry;
    logic [31:0] rcolor;
    lfsr        = 16'd52;
    rst_n       = 1'b0;
    hb_csn_de   = 1'b1;
    hb_wstrb    = 1'b0;
    hb_adr      = '0;
    hb_din      = '0;
    hb_xyw_csn  = 1'b1;
    hb_win_adr  = '0;
    mc_busy     = 1'b0;
    stall_en    = 1'b0;
    win_pending = 1'b0;
    tog_exp     = 1'b0;
    fill_writes = 0;
    exp_data    = '0;
    rand_bits(3, r);
    rw = 12'(r) + 12'd2;
    rand_bits(2, r);
    rh = 12'(r) + 12'd1;
    rand_bits(4, r);
    rx = 12'(r);
    rand_bits(4, r);
    ry = 12'(r);
    rand_bits(32, rcolor);
    wd_cycles = 20 * (15 + int'(rw) * int'(rh) + 25 + 4) + 600;
    wd_armed  = 1'b1;

    repeat (8) @(posedge hb_clk);
    #1;
    rst_n = 1'b1;
    @(posedge hb_clk);
    check_value("fb_we", fb_we, 0);
    check_value("busy_hb", busy_hb, 0);
    check_value("dx_deb", dx_deb, 0);
    check_value("interrupt", interrupt, 0);
    #1;

    // Register readback
    reg_write(REG_DORG, 32'hFF12_3456);
    check_reg(REG_DORG, 32'h0012_3456, "hb_dout dorg");
    reg_write(REG_PITCH, 32'h0000_F040);
    check_reg(REG_PITCH, 32'h0000_0040, "hb_dout pitch");
    reg_write(REG_FORE, 32'hDEAD_BEEF);
    check_reg(REG_FORE, 32'hDEAD_BEEF, "hb_dout fore");
    reg_write(REG_XY0, 32'hF123_F456);
    check_reg(REG_XY0, 32'h0123_0456, "hb_dout xy0");
    reg_write(REG_WH, 32'hA987_6543);
    check_reg(REG_WH, 32'h0987_0543, "hb_dout wh");
    reg_write(REG_CMD, 32'h0000_0002);
    check_reg(REG_CMD, 32'h0000_0002, "hb_dout cmd");
    reg_write(REG_CMD, 32'h0000_0000);

    run_fill(24'h00_1000, 12'd64, 12'd3, 12'd2, 12'd5, 12'd3, 32'hA5A5_1234, 0, 0, 0);
    run_fill(24'h04_0000, 12'd80, rx, ry, rw, rh, rcolor, 0, 1, 0);
    run_fill(24'h02_0000, 12'd100, 12'd10, 12'd5, 12'd6, 12'd4, 32'h1357_9BDF, 0, 1, 1);

    // Interrupt set and clear
    run_fill(24'h08_0000, 12'd32, 12'd1, 12'd1, 12'd2, 12'd2, 32'h0F0F_F0F0, 1, 0, 0);
    check_reg(REG_STAT, 32'h0000_0002, "hb_dout stat");
    reg_write(REG_STAT, 32'h0000_0002);
    check_reg(REG_STAT, 32'h0000_0000, "hb_dout stat");
    check_value("interrupt", interrupt, 0);

    run_fill(24'h08_0000, 12'd32, 12'd1, 12'd1, 12'd0, 12'd3, 32'h0F0F_F0F0, 0, 0, 0);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/de_blt_fill.sv */
`timescale 1ns/100ps
`default_nettype none

module de_blt_fill import de_pkg::*; (
  input  logic               hb_clk,
  input  logic               rst_n,
  input  logic               cmd_go,
  input  logic [FB_AW-1:0]   dorg,
  input  logic [COORD_W-1:0] pitch,
  input  logic [PIX_W-1:0]   fore,
  input  logic [COORD_W-1:0] xy0_x,
  input  logic [COORD_W-1:0] xy0_y,
  input  logic [COORD_W-1:0] wid,
  input  logic [COORD_W-1:0] hgt,
  input  logic               fill_gnt,
  output logic               fill_req,
  output logic [FB_AW-1:0]   fill_addr,
  output logic [PIX_W-1:0]   fill_data,
  output logic               fill_busy,
  output logic               fill_done
);

  logic [COORD_W-1:0] x_cnt, y_cnt;
  logic [COORD_W-1:0] wid_q, hgt_q, pitch_q;   // Held for the whole command
  logic [FB_AW-1:0]   row_base;
  logic [FB_AW-1:0]   start_addr;
  logic               size_zero;
  logic               x_last, y_last;

  assign size_zero  = (wid == '0) || (hgt == '0);
  assign start_addr = dorg + FB_AW'(xy0_y) * FB_AW'(pitch) + FB_AW'(xy0_x);
  assign x_last     = (x_cnt == wid_q - 1'b1);
  assign y_last     = (y_cnt == hgt_q - 1'b1);
  assign fill_addr  = row_base + FB_AW'(x_cnt);

  // Command parameters
  always_ff @(posedge hb_clk) begin
    if (cmd_go) begin
      wid_q     <= wid;
      hgt_q     <= hgt;
      pitch_q   <= pitch;
      fill_data <= fore;
    end
  end

  // Row-major walk, one pixel in flight
  always_ff @(posedge hb_clk) begin
    if (!rst_n) begin
      fill_busy <= 1'b0;
      fill_req  <= 1'b0;
      fill_done <= 1'b0;
      x_cnt     <= '0;
      y_cnt     <= '0;
      row_base  <= '0;
    end else begin
      fill_done <= 1'b0;
      if (cmd_go) begin
        fill_busy <= 1'b1;
        fill_req  <= !size_zero;
        fill_done <= size_zero;               // Empty rectangle ends at once
        x_cnt     <= '0;
        y_cnt     <= '0;
        row_base  <= start_addr;
      end else if (fill_done) begin
        fill_busy <= 1'b0;
      end else if (fill_req && fill_gnt) begin
        if (x_last) begin
          x_cnt    <= '0;
          y_cnt    <= y_cnt + 1'b1;
          row_base <= row_base + FB_AW'(pitch_q);
          if (y_last) begin
            fill_req  <= 1'b0;
            fill_done <= 1'b1;
          end
        end else begin
          x_cnt <= x_cnt + 1'b1;
        end
      end
    end
  end

  a_req_hold: assert property (@(posedge hb_clk) disable iff (!rst_n)
    fill_req && !fill_gnt |=> fill_req && $stable(fill_addr));

endmodule

`default_nettype wire

/* verilog/de_fb_arb.sv */
`timescale 1ns/100ps
`default_nettype none

module de_fb_arb import de_pkg::*; (
  input  logic             hb_clk,
  input  logic             rst_n,
  input  logic             win_req,
  input  logic [FB_AW-1:0] win_addr,
  input  logic [PIX_W-1:0] win_data,
  input  logic             fill_req,
  input  logic [FB_AW-1:0] fill_addr,
  input  logic [PIX_W-1:0] fill_data,
  input  logic             mc_busy,
  output logic             win_gnt,
  output logic             fill_gnt,
  output logic             fb_we,
  output logic [FB_AW-1:0] fb_addr,
  output logic [PIX_W-1:0] fb_data
);

  ////////////////////////////////////////
  // Fixed priority, host window first
  ////////////////////////////////////////

  // Nothing moves while the memory controller is busy
  assign win_gnt  = win_req && !mc_busy;
  assign fill_gnt = fill_req && !win_req && !mc_busy;
  assign fb_we    = win_gnt || fill_gnt;

  // Steer the winner onto the port
  always_comb begin
    if (win_gnt) begin
      fb_addr = win_addr;
      fb_data = win_data;
    end else begin
      fb_addr = fill_addr;
      fb_data = fill_data;
    end
  end

  a_one_gnt: assert property (@(posedge hb_clk) disable iff (!rst_n)
    !(win_gnt && fill_gnt));

  // A stalled window request must still be there next cycle
  a_win_wait: assert property (@(posedge hb_clk) disable iff (!rst_n)
    win_req && !win_gnt |=> win_req);

endmodule

`default_nettype wire

/* verilog/de_host_window.sv */
`timescale 1ns/100ps
`default_nettype none

module de_host_window import de_pkg::*; (
  input  logic             hb_clk,
  input  logic             rst_n,
  input  logic             hb_xyw_csn,
  input  logic             hb_wstrb,
  input  logic [FB_AW-1:0] hb_win_adr,
  input  logic [PIX_W-1:0] hb_din,
  input  logic [FB_AW-1:0] dorg,
  input  logic             win_gnt,
  output logic             win_req,
  output logic [FB_AW-1:0] win_addr,
  output logic [PIX_W-1:0] win_data,
  output logic             busy_hb
);

  logic win_wr;
  logic pending;

  assign win_wr  = !hb_xyw_csn && hb_wstrb;
  assign win_req = pending;
  assign busy_hb = pending;    // Host holds off while a word waits

  always_ff @(posedge hb_clk) begin
    if (!rst_n)
      pending <= 1'b0;
    else if (win_gnt)
      pending <= 1'b0;
    else if (win_wr)
      pending <= 1'b1;
  end

  // Word offset relative to the destination origin
  always_ff @(posedge hb_clk) begin
    if (win_wr && !pending) begin
      win_addr <= dorg + hb_win_adr;
      win_data <= hb_din;
    end
  end

  a_no_overrun: assert property (@(posedge hb_clk) disable iff (!rst_n)
    busy_hb |-> !win_wr);

endmodule

`default_nettype wire

/* verilog/de_pkg.sv */
`default_nettype none

package de_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int COORD_W = 12;      // One x, y, width or height
  localparam int FB_AW   = 24;      // Frame buffer word address
  localparam int PIX_W   = 32;      // Pixel and host data word
  localparam int REG_AW  = 7;       // Host register word address

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [REG_AW-1:0] REG_DORG  = 7'd0;  // Destination origin
  localparam logic [REG_AW-1:0] REG_PITCH = 7'd1;  // Words per row
  localparam logic [REG_AW-1:0] REG_FORE  = 7'd2;  // Foreground color
  localparam logic [REG_AW-1:0] REG_XY0   = 7'd3;  // Start corner
  localparam logic [REG_AW-1:0] REG_WH    = 7'd4;  // Width and height
  localparam logic [REG_AW-1:0] REG_CMD   = 7'd5;
  localparam logic [REG_AW-1:0] REG_STAT  = 7'd6;

  // Command word
  localparam int CMD_GO_BIT = 0;    // Start a fill
  localparam int CMD_IE_BIT = 1;    // Interrupt on done

  // Status word, write 1 to the int bit to clear it
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_INT_BIT  = 1;

  ////////////////////////////////////////
  // Register word views
  ////////////////////////////////////////

  // Coordinate pair, x low and y in the upper half
  typedef struct packed {
    logic [PIX_W-COORD_W-16-1:0] rsvd_hi;
    logic [COORD_W-1:0]          y;
    logic [16-COORD_W-1:0]       rsvd_lo;
    logic [COORD_W-1:0]          x;
  } reg_xy_t;

  // Same host word, read either raw or as an x/y pair
  typedef union packed {
    logic [PIX_W-1:0] raw;
    reg_xy_t          xy;
  } reg_word_u;

endpackage

`default_nettype wire

/* verilog/de_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module de_regs import de_pkg::*; (
  input  logic               hb_clk,
  input  logic               rst_n,
  input  logic               hb_csn_de,
  input  logic               hb_wstrb,
  input  logic [REG_AW-1:0]  hb_adr,
  input  logic [PIX_W-1:0]   hb_din,
  input  logic               fill_busy,
  input  logic               fill_done,
  output logic [PIX_W-1:0]   hb_dout,
  output logic               cmd_go,
  output logic [FB_AW-1:0]   dorg,
  output logic [COORD_W-1:0] pitch,
  output logic [PIX_W-1:0]   fore,
  output logic [COORD_W-1:0] xy0_x,
  output logic [COORD_W-1:0] xy0_y,
  output logic [COORD_W-1:0] wid,
  output logic [COORD_W-1:0] hgt,
  output logic               dx_deb,
  output logic               de_ddint_tog,
  output logic               interrupt
);

  logic      reg_wr;
  logic      cmd_ie;
  reg_word_u wr_word;
  reg_word_u rd_word;

  assign reg_wr  = !hb_csn_de && hb_wstrb;
  assign wr_word = reg_word_u'(hb_din);
  assign dx_deb  = fill_busy;              // Engine busy straight from the walker

  ////////////////////////////////////////
  // Host writes
  ////////////////////////////////////////

  always_ff @(posedge hb_clk) begin
    if (!rst_n) begin
      dorg         <= '0;
      pitch        <= '0;
      fore         <= '0;
      xy0_x        <= '0;
      xy0_y        <= '0;
      wid          <= '0;
      hgt          <= '0;
      cmd_ie       <= 1'b0;
      cmd_go       <= 1'b0;
      de_ddint_tog <= 1'b0;
      interrupt    <= 1'b0;
    end else begin
      cmd_go <= 1'b0;
      if (reg_wr) begin
        case (hb_adr)
          REG_DORG:  dorg  <= hb_din[FB_AW-1:0];
          REG_PITCH: pitch <= hb_din[COORD_W-1:0];
          REG_FORE:  fore  <= hb_din;
          REG_XY0: begin
            xy0_x <= wr_word.xy.x;
            xy0_y <= wr_word.xy.y;
          end
          REG_WH: begin
            wid <= wr_word.xy.x;
            hgt <= wr_word.xy.y;
          end
          REG_CMD: begin
            cmd_ie <= hb_din[CMD_IE_BIT];
            cmd_go <= hb_din[CMD_GO_BIT] && !fill_busy && !cmd_go; // Dropped if busy
          end
          default: ;
        endcase
      end
      // Done wins over a clear in the same cycle
      if (fill_done) begin
        de_ddint_tog <= ~de_ddint_tog;
        if (cmd_ie)
          interrupt <= 1'b1;
      end else if (reg_wr && hb_adr == REG_STAT && hb_din[STAT_INT_BIT]) begin
        interrupt <= 1'b0;
      end
    end
  end

  // Readback
  always_comb begin
    rd_word = '0;
    case (hb_adr)
      REG_DORG:  rd_word.raw = PIX_W'(dorg);
      REG_PITCH: rd_word.raw = PIX_W'(pitch);
      REG_FORE:  rd_word.raw = fore;
      REG_XY0: begin
        rd_word.xy.x = xy0_x;
        rd_word.xy.y = xy0_y;
      end
      REG_WH: begin
        rd_word.xy.x = wid;
        rd_word.xy.y = hgt;
      end
      REG_CMD: rd_word.raw[CMD_IE_BIT] = cmd_ie;
      REG_STAT: begin
        rd_word.raw[STAT_BUSY_BIT] = fill_busy;
        rd_word.raw[STAT_INT_BIT]  = interrupt;
      end
      default: ;
    endcase
    hb_dout = rd_word.raw;
  end

  // Walker must stay idle from the go write to the start pulse
  a_go_idle: assert property (@(posedge hb_clk) disable iff (!rst_n)
    cmd_go |-> !fill_busy);

endmodule

`default_nettype wire

/* verilog/de_top.sv */
`timescale 1ns/100ps
`default_nettype none

module de_top import de_pkg::*; (
  input  logic              hb_clk,
  input  logic              rst_n,
  // Host register access
  input  logic              hb_csn_de,
  input  logic              hb_wstrb,
  input  logic [REG_AW-1:0] hb_adr,
  input  logic [PIX_W-1:0]  hb_din,
  output logic [PIX_W-1:0]  hb_dout,
  // Host XY window
  input  logic              hb_xyw_csn,
  input  logic [FB_AW-1:0]  hb_win_adr,
  output logic              busy_hb,
  // Frame buffer write port
  output logic              fb_we,
  output logic [FB_AW-1:0]  fb_addr,
  output logic [PIX_W-1:0]  fb_data,
  input  logic              mc_busy,
  // Status
  output logic              dx_deb,
  output logic              de_ddint_tog,
  output logic              interrupt
);

  logic               cmd_go;
  logic [FB_AW-1:0]   dorg;
  logic [COORD_W-1:0] pitch;
  logic [PIX_W-1:0]   fore;
  logic [COORD_W-1:0] xy0_x, xy0_y;
  logic [COORD_W-1:0] wid, hgt;
  logic               fill_busy, fill_done;
  logic               fill_req, fill_gnt;
  logic [FB_AW-1:0]   fill_addr;
  logic [PIX_W-1:0]   fill_data;
  logic               win_req, win_gnt;
  logic [FB_AW-1:0]   win_addr;
  logic [PIX_W-1:0]   win_data;

  de_regs de_regs_inst (
    .hb_clk, .rst_n, .hb_csn_de, .hb_wstrb, .hb_adr, .hb_din,
    .fill_busy, .fill_done, .hb_dout, .cmd_go, .dorg, .pitch, .fore,
    .xy0_x, .xy0_y, .wid, .hgt, .dx_deb, .de_ddint_tog, .interrupt
  );

  de_blt_fill de_blt_fill_inst (
    .hb_clk, .rst_n, .cmd_go, .dorg, .pitch, .fore, .xy0_x, .xy0_y,
    .wid, .hgt, .fill_gnt, .fill_req, .fill_addr, .fill_data,
    .fill_busy, .fill_done
  );

  de_host_window de_host_window_inst (
    .hb_clk, .rst_n, .hb_xyw_csn, .hb_wstrb, .hb_win_adr, .hb_din,
    .dorg, .win_gnt, .win_req, .win_addr, .win_data, .busy_hb
  );

  de_fb_arb de_fb_arb_inst (
    .hb_clk, .rst_n, .win_req, .win_addr, .win_data, .fill_req,
    .fill_addr, .fill_data, .mc_busy, .win_gnt, .fill_gnt,
    .fb_we, .fb_addr, .fb_data
  );

endmodule

`default_nettype wire

/* vlog.f */
verilog/de_pkg.sv
verilog/de_regs.sv
verilog/de_blt_fill.sv
verilog/de_host_window.sv
verilog/de_fb_arb.sv
verilog/de_top.sv
sim/tb_de_top.sv
